// File: rtl/cachePkg.sv
package cachePkg;

  ////////////////////
  // Geometry
  ////////////////////
  localparam int AdrBits    = 16;                              // Byte address
  localparam int WordBits   = 32;                              // Processor word
  localparam int LineBits   = 128;                             // Four words per line
  localparam int OffsetBits = 4;                               // Byte offset in a line
  localparam int SetBits    = 4;
  localparam int NumSets    = 1 << SetBits;
  localparam int TagBits    = AdrBits - SetBits - OffsetBits;

  // Byte address, seen either as a bus word or as lookup fields
  typedef union packed {
    logic [AdrBits-1:0] raw;
    struct packed {
      logic [TagBits-1:0] tag;
      logic [SetBits-1:0] set;
      logic [1:0]         wordSel;                             // Word within the line
      logic [1:0]         byteSel;                             // Byte within the word
    } fields;
  } cacheAdrT;

  // Controller states
  typedef enum logic [2:0] {
    idle,
    lookup,                                                    // Tag compare on registered set
    writeback,                                                 // Dirty victim out to memory
    fetch,                                                     // Missing line in from memory
    fill,                                                      // Fetched line into the victim way
    flushCheck,
    flushWrite,
    flushDone
  } cacheStateT;

endpackage

// File: rtl/cacheWay.sv
`timescale 1ns/1ps

module cacheWay import cachePkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [SetBits-1:0]    setIdx,
  input  logic [TagBits-1:0]    tag,            // Tag of the current request
  input  logic                  wayWrite,
  input  logic [LineBits-1:0]   lineWriteData,
  input  logic [LineBits/8-1:0] lineByteMask,
  input  logic                  setValid,       // Fill, also loads the tag
  input  logic                  setDirty,
  input  logic                  clearDirty,
  output logic                  hit,
  output logic                  valid,
  output logic                  dirty,
  output logic [TagBits-1:0]    tagOut,
  output logic [LineBits-1:0]   readLine
);

  logic [TagBits-1:0]  tagMem  [NumSets];
  logic [LineBits-1:0] lineMem [NumSets];
  logic [NumSets-1:0]  validBits;
  logic [NumSets-1:0]  dirtyBits;
  logic [TagBits-1:0]  nextTag;
  logic [LineBits-1:0] nextLine;
  logic                nextValid;
  logic                nextDirty;

  // Entry at setIdx as it stands after this edge, so a write shows up in the readout at once
  always_comb begin
    nextTag   = tagMem[setIdx];
    nextLine  = lineMem[setIdx];
    nextValid = validBits[setIdx];
    nextDirty = dirtyBits[setIdx];
    if (wayWrite) begin
      if (setValid) begin
        nextTag   = tag;
        nextValid = 1'b1;
      end
      if (setDirty) nextDirty = 1'b1;
      else if (clearDirty) nextDirty = 1'b0;
      for (int b = 0; b < LineBits/8; b++) begin
        if (lineByteMask[b]) nextLine[8*b +: 8] = lineWriteData[8*b +: 8];  // Byte lanes
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wayWrite) begin
      tagMem[setIdx]  <= nextTag;
      lineMem[setIdx] <= nextLine;
    end
    tagOut   <= nextTag;                        // Synchronous readout
    readLine <= nextLine;
  end

  // Status bits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validBits <= '0;
      dirtyBits <= '0;
      valid     <= 1'b0;
      dirty     <= 1'b0;
    end else begin
      if (wayWrite) begin
        validBits[setIdx] <= nextValid;
        dirtyBits[setIdx] <= nextDirty;
      end
      valid <= nextValid;
      dirty <= nextDirty;
    end
  end

  assign hit = valid && (tagOut == tag);        // Compare in lookup

  // Controller never asks for both dirty updates at once
  assert property (@(posedge clk) disable iff (!rstN) !(setDirty && clearDirty));

endmodule

// File: rtl/cacheLru.sv
`timescale 1ns/1ps

module cacheLru import cachePkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  logic [SetBits-1:0] setIdx,
  input  logic               lruWrite,    // Hit or fill in this set
  input  logic               usedWay,     // Way just touched
  output logic               victimWay    // Least recently used way
);

  ////////////////////
  // One bit per set
  ////////////////////
  logic [NumSets-1:0] lruBits;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lruBits <= '0;                         // Way 0 goes first after reset
    end else if (lruWrite) begin
      lruBits[setIdx] <= ~usedWay;           // Other way becomes the older one
    end
  end

  // Two ways, so the stored bit names the victim directly
  assign victimWay = lruBits[setIdx];

endmodule

// File: rtl/cacheFsm.sv
`timescale 1ns/1ps

module cacheFsm import cachePkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       cpuReq,
  input  logic       cpuWrite,
  input  logic       flushReq,
  input  logic       busAck,
  input  logic       cacheHit,
  input  logic       victimDirty,      // Victim is valid and dirty
  input  logic       flushLineDirty,   // Line under the flush counter needs writeback
  input  logic       flushDoneFlag,    // Counter on the last way of the last set
  output logic       cpuAck,
  output logic       flushAck,
  output logic       busReq,
  output logic       busWrite,
  output logic       selWriteback,
  output logic       selFlushAdr,
  output logic       wayWriteEn,
  output logic       setValid,
  output logic       setDirty,
  output logic       clearDirty,
  output logic       lruWrite,
  output logic       flushCntEn,
  output logic       flushCntClear,
  output logic       hitPulse,
  output logic       missPulse,
  output cacheStateT state
);

  logic busPhase;                      // busReq dropped, waiting for busAck low
  logic ackDelay;                      // Hit decided, cpuAck rises on next edge
  logic refill;                        // Current lookup follows our own fill
  logic lookupHit;
  logic busDone;
  logic cpuStart;
  logic flushStart;

  assign lookupHit  = (state == lookup) && cacheHit;
  assign busDone    = busPhase && !busAck;                       // Bus back to rest
  assign cpuStart   = (state == idle) && cpuReq && !cpuAck && !ackDelay;
  assign flushStart = (state == idle) && flushReq && !cpuReq;    // cpuReq has priority

  ////////////////////
  // State and handshakes
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= idle;
      cpuAck    <= 1'b0;
      busReq    <= 1'b0;
      busPhase  <= 1'b0;
      ackDelay  <= 1'b0;
      refill    <= 1'b0;
      hitPulse  <= 1'b0;
      missPulse <= 1'b0;
    end else begin
      hitPulse  <= 1'b0;
      missPulse <= 1'b0;
      ackDelay  <= 1'b0;
      if (ackDelay) cpuAck <= 1'b1;
      else if (cpuAck && !cpuReq) cpuAck <= 1'b0;             // Release phase

      // Four-phase line transfer, shared by the three bus states
      if (state inside {writeback, fetch, flushWrite}) begin
        if (!busPhase) begin
          busReq   <= !(busReq && busAck);
          busPhase <= busReq && busAck;
        end else if (!busAck) begin
          busPhase <= 1'b0;
        end
      end

      case (state)
        idle: begin
          if (cpuStart) state <= lookup;
          else if (flushStart) state <= flushCheck;
        end
        lookup: begin
          if (cacheHit) begin
            state    <= idle;
            ackDelay <= 1'b1;
            hitPulse <= !refill;                               // Count the request once
            refill   <= 1'b0;
          end else begin
            state     <= victimDirty ? writeback : fetch;
            missPulse <= 1'b1;
            refill    <= 1'b1;
          end
        end
        writeback:  if (busDone) state <= fetch;
        fetch:      if (busDone) state <= fill;
        fill:       state <= lookup;                           // Retry, now a hit
        flushCheck: begin
          if (flushLineDirty) state <= flushWrite;
          else if (flushDoneFlag) state <= flushDone;
        end
        flushWrite: if (busDone) state <= flushCheck;         // Recheck the cleaned line
        flushDone:  if (!flushReq) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  ////////////////////
  // Array and datapath controls
  ////////////////////
  assign flushAck      = state == flushDone;
  assign busWrite      = (state == writeback) || (state == flushWrite);
  assign selWriteback  = state == writeback;
  assign selFlushAdr   = flushStart || (state inside {flushCheck, flushWrite, flushDone});
  assign wayWriteEn    = (lookupHit && cpuWrite) || (state == fill) ||
                         (state == flushWrite && busDone);
  assign setValid      = state == fill;
  assign setDirty      = cpuWrite && (lookupHit || state == fill);
  assign clearDirty    = (state == fill && !cpuWrite) || (state == flushWrite && busDone);
  assign lruWrite      = lookupHit || (state == fill);
  assign flushCntEn    = (state == flushCheck) && !flushLineDirty && !flushDoneFlag;
  assign flushCntClear = state == idle;

  // busReq holds until the memory answers
  assert property (@(posedge clk) disable iff (!rstN) busReq && !busAck |=> busReq);
  // cpuAck only with a live request or in the cycle after it dropped
  assert property (@(posedge clk) disable iff (!rstN) cpuAck |-> cpuReq || $past(cpuReq));

endmodule

// File: rtl/dataCache.sv
`timescale 1ns/1ps

module dataCache import cachePkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  // Processor side
  input  logic                  cpuReq,
  input  logic                  cpuWrite,
  input  logic [AdrBits-1:0]    cpuAdr,
  input  logic [WordBits-1:0]   cpuWriteData,
  input  logic [WordBits/8-1:0] cpuByteMask,
  output logic [WordBits-1:0]   cpuReadData,
  output logic                  cpuAck,
  // Flush
  input  logic                  flushReq,
  output logic                  flushAck,
  // Line bus
  output logic                  busReq,
  output logic                  busWrite,
  output logic [AdrBits-1:0]    busAdr,          // Line aligned
  output logic [LineBits-1:0]   busWriteLine,
  input  logic                  busAck,
  input  logic [LineBits-1:0]   busReadLine,
  // Statistics
  output logic                  hitPulse,
  output logic                  missPulse
);

  localparam int LineBytes = LineBits/8;

  cacheAdrT             reqAdr;
  cacheStateT           state;
  logic [SetBits-1:0]   setIdx;
  logic [SetBits-1:0]   flushSet;
  logic [SetBits-1:0]   flushSetIdx;
  logic [SetBits:0]     flushCnt;                 // {set, way}
  logic [SetBits:0]     flushCntNext;
  logic                 flushWay;
  logic [1:0]           wayHit;
  logic [1:0]           wayValid;
  logic [1:0]           wayDirty;
  logic [1:0]           wayWr;
  logic [TagBits-1:0]   wayTag [2];
  logic [LineBits-1:0]  wayLine [2];
  logic                 cacheHit;
  logic                 lruVictim;
  logic                 victimWay;
  logic                 pickWay;                  // Way being written, hit or sent out
  logic                 victimDirty;
  logic                 flushLineDirty;
  logic                 flushDoneFlag;
  logic                 selWriteback;
  logic                 selFlushAdr;
  logic                 wayWriteEn;
  logic                 setValid;
  logic                 setDirty;
  logic                 clearDirty;
  logic                 lruWrite;
  logic                 flushCntEn;
  logic                 flushCntClear;
  logic [LineBits-1:0]  hitLine;
  logic [LineBits-1:0]  fetchLine;
  logic [LineBits-1:0]  lineWriteData;
  logic [LineBytes-1:0] storeMask;
  logic [LineBytes-1:0] lineByteMask;

  ////////////////////
  // Set select
  ////////////////////
  assign reqAdr.raw   = cpuAdr;
  assign flushCntNext = flushCnt + 1'b1;
  assign flushSet     = flushCnt[SetBits:1];
  assign flushWay     = flushCnt[0];
  assign flushSetIdx  = flushCntEn ? flushCntNext[SetBits:1] : flushSet;  // Read ahead on a step
  assign setIdx       = selFlushAdr ? flushSetIdx : reqAdr.fields.set;

  for (genvar w = 0; w < 2; w++) begin : gWay
    cacheWay way (
      .clk, .rstN, .setIdx, .tag(reqAdr.fields.tag), .wayWrite(wayWr[w]),
      .lineWriteData, .lineByteMask, .setValid, .setDirty, .clearDirty,
      .hit(wayHit[w]), .valid(wayValid[w]), .dirty(wayDirty[w]),
      .tagOut(wayTag[w]), .readLine(wayLine[w]));
  end

  cacheLru lru (.clk, .rstN, .setIdx, .lruWrite, .usedWay(pickWay), .victimWay(lruVictim));

  assign cacheHit  = |wayHit;
  assign victimWay = !wayValid[0] ? 1'b0 : !wayValid[1] ? 1'b1 : lruVictim;  // Empty way first
  assign pickWay   = selFlushAdr ? flushWay : cacheHit ? wayHit[1] : victimWay;
  assign wayWr     = wayWriteEn ? (pickWay ? 2'b10 : 2'b01) : 2'b00;
  assign victimDirty    = wayValid[victimWay] && wayDirty[victimWay];
  assign flushLineDirty = wayValid[flushWay] && wayDirty[flushWay];
  assign flushDoneFlag  = &flushCnt;

  ////////////////////
  // Read path
  ////////////////////
  assign hitLine = (wayHit[0] ? wayLine[0] : '0) | (wayHit[1] ? wayLine[1] : '0);

  // Word held for the whole ack phase
  always_ff @(posedge clk) begin
    if (state == lookup && cacheHit) begin
      cpuReadData <= hitLine[WordBits*reqAdr.fields.wordSel +: WordBits];
    end
  end

  ////////////////////
  // Write path
  ////////////////////
  assign storeMask = cpuWrite ? LineBytes'(cpuByteMask) << ((WordBits/8)*reqAdr.fields.wordSel)
                              : '0;

  // Store bytes over the fetched line, also used as is for a store hit
  always_comb begin
    for (int b = 0; b < LineBytes; b++) begin
      lineWriteData[8*b +: 8] = storeMask[b] ? cpuWriteData[8*(b%(WordBits/8)) +: 8]
                                             : fetchLine[8*b +: 8];
    end
  end
  assign lineByteMask = setValid ? '1 : setDirty ? storeMask : '0;  // Flush clean writes no data

  always_ff @(posedge clk) begin
    if (state == fetch && busAck) fetchLine <= busReadLine;         // Valid only while acked
  end

  // Bus address and outgoing line
  assign busAdr = selFlushAdr  ? {wayTag[flushWay], flushSet, {OffsetBits{1'b0}}} :
                  selWriteback ? {wayTag[victimWay], reqAdr.fields.set, {OffsetBits{1'b0}}} :
                                 {reqAdr.fields.tag, reqAdr.fields.set, {OffsetBits{1'b0}}};
  assign busWriteLine = wayLine[pickWay];

  ////////////////////
  // Flush walk
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN || flushCntClear) begin
      flushCnt <= '0;
    end else if (flushCntEn) begin
      flushCnt <= flushCntNext;                                    // Way 0, way 1, next set
    end
  end

  cacheFsm fsm (
    .clk, .rstN, .cpuReq, .cpuWrite, .flushReq, .busAck, .cacheHit, .victimDirty,
    .flushLineDirty, .flushDoneFlag, .cpuAck, .flushAck, .busReq, .busWrite,
    .selWriteback, .selFlushAdr, .wayWriteEn, .setValid, .setDirty, .clearDirty,
    .lruWrite, .flushCntEn, .flushCntClear, .hitPulse, .missPulse, .state);

  // A tag lives in at most one way of a set
  assert property (@(posedge clk) disable iff (!rstN) state == lookup |-> !(&wayHit));

endmodule

// File: tests/memModel.sv
`timescale 1ns/1ps

module memModel import cachePkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                busReq,
  input  logic                busWrite,
  input  logic [AdrBits-1:0]  busAdr,          // Line aligned
  input  logic [LineBits-1:0] busWriteLine,
  output logic                busAck,
  output logic [LineBits-1:0] busReadLine
);

  localparam int NumLines = 1 << (AdrBits - OffsetBits);

  logic [LineBits-1:0] lineMem [NumLines];      // Backing store, one entry per line
  logic [31:0]         rndState;
  logic [2:0]          waitCnt;
  logic                busy;                    // Request seen, delay running

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Each word holds its own byte address and the inverse of it
  initial begin
    logic [AdrBits-1:0] wordAdr;
    for (int i = 0; i < NumLines; i++) begin
      for (int w = 0; w < 4; w++) begin
        wordAdr = {i[11:0], w[1:0], 2'b00};
        lineMem[i][32*w +: 32] = {~wordAdr, wordAdr};
      end
    end
  end

  ////////////////////
  // Four-phase slave
  ////////////////////
  always @(posedge clk) begin
    if (!rstN) begin
      busAck   <= 1'b0;
      busy     <= 1'b0;
      waitCnt  <= '0;
      rndState <= 32'd39154;
    end else if (busAck) begin
      if (!busReq) busAck <= 1'b0;              // Release phase
    end else if (busReq && !busy) begin
      busy     <= 1'b1;
      waitCnt  <= rndState[2:0];                // 0 to 7 stall cycles
      rndState <= xorshift32(rndState);
    end else if (busy) begin
      if (waitCnt != 0) begin
        waitCnt <= waitCnt - 1'b1;
      end else begin
        busy   <= 1'b0;
        busAck <= 1'b1;
        if (busWrite) lineMem[busAdr[AdrBits-1:OffsetBits]] <= busWriteLine;
        else busReadLine <= lineMem[busAdr[AdrBits-1:OffsetBits]];  // Held while acked
      end
    end
  end

endmodule

// File: tests/tbDataCache.sv
`timescale 1ns/1ps

module tbDataCache import cachePkg::*; ();

  localparam int ClkPeriod  = 100;
  localparam int NumOps     = 120;                         // Random accesses, each repeated
  localparam int LruOps     = 6;
  localparam int OpBudget   = 400;                         // Cycles per access
  localparam int WalkCycles = 2 * NumSets * 40;            // Flush walk with every way dirty
  localparam int NumLines   = 1 << (AdrBits - OffsetBits);
  localparam int WatchdogCycles = 16 + OpBudget * (2 * NumOps + LruOps) + 2 * WalkCycles;

  logic                  clk = 1'b0;
  logic                  rstN;
  logic                  cpuReq;
  logic                  cpuWrite;
  logic [AdrBits-1:0]    cpuAdr;
  logic [WordBits-1:0]   cpuWriteData;
  logic [WordBits/8-1:0] cpuByteMask;
  logic [WordBits-1:0]   cpuReadData;
  logic                  cpuAck;
  logic                  flushReq;
  logic                  flushAck;
  logic                  busReq;
  logic                  busWrite;
  logic [AdrBits-1:0]    busAdr;
  logic [LineBits-1:0]   busWriteLine;
  logic                  busAck;
  logic [LineBits-1:0]   busReadLine;
  logic                  hitPulse;
  logic                  missPulse;

  logic [LineBits-1:0]   shadowLine [NumLines];            // Memory as the processor sees it
  logic [NumLines-1:0]   storedSince;                      // Stored to since last bus write
  logic [WordBits-1:0]   expectedWord;
  logic                  expHit;
  logic                  expMiss;
  logic                  missSeen;                         // Miss strobe within this access
  logic                  quietBus;
  logic                  started;
  logic [31:0]           rndState;

  always #(ClkPeriod/2) clk = ~clk;

  dataCache dut0 (
    .clk, .rstN, .cpuReq, .cpuWrite, .cpuAdr, .cpuWriteData, .cpuByteMask, .cpuReadData,
    .cpuAck, .flushReq, .flushAck, .busReq, .busWrite, .busAdr, .busWriteLine, .busAck,
    .busReadLine, .hitPulse, .missPulse);

  memModel mem0 (.clk, .rstN, .busReq, .busWrite, .busAdr, .busWriteLine, .busAck, .busReadLine);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic reportFailure(input string detail);
    $display("SIMULATION FAILED");
    $display("%s", detail);
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #5;                                                    // Drive just after the edge
  endtask

  // Full four-phase access, shadow updated once a store is acknowledged
  task automatic access(input logic write, input logic [AdrBits-1:0] adr,
                        input logic [WordBits-1:0] data, input logic [3:0] mask,
                        input logic mustHit, input logic mustMiss);
    logic [LineBits-1:0] line;
    line         = shadowLine[adr[AdrBits-1:OffsetBits]];
    expectedWord = line[WordBits*adr[3:2] +: WordBits];
    cpuWrite     = write;
    cpuAdr       = adr;
    cpuWriteData = data;
    cpuByteMask  = mask;
    expHit       = mustHit;
    expMiss      = mustMiss;
    missSeen     = 1'b0;
    started      = 1'b1;
    cpuReq       = 1'b1;
    while (!cpuAck) nextCycle();
    cpuReq = 1'b0;
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) line[WordBits*adr[3:2] + 8*b +: 8] = data[8*b +: 8];  // Byte lanes
      end
      shadowLine[adr[AdrBits-1:OffsetBits]]  = line;
      storedSince[adr[AdrBits-1:OffsetBits]] = 1'b1;
    end
    while (cpuAck) nextCycle();                            // Release phase
    expHit  = 1'b0;
    expMiss = 1'b0;
  endtask

  task automatic flushCache(input logic mustBeQuiet);
    quietBus = mustBeQuiet;
    started  = 1'b1;
    flushReq = 1'b1;
    while (!flushAck) nextCycle();
    flushReq = 1'b0;
    while (flushAck) nextCycle();
    quietBus = 1'b0;
  endtask

  task automatic compareMemory();
    for (int i = 0; i < NumLines; i++) begin
      assert (mem0.lineMem[i] == shadowLine[i])
        else reportFailure($sformatf("FAILED mem0.lineMem[%h] = %h, expected %h",
                                     i, mem0.lineMem[i], shadowLine[i]));
    end
  endtask

  // Bus write leaves the line clean in memory
  always @(posedge clk) begin
    if (busReq && busWrite && busAck) storedSince[busAdr[AdrBits-1:OffsetBits]] = 1'b0;
    if (missPulse) missSeen = 1'b1;
  end

  ////////////////////
  // Checks
  ////////////////////
  assert property (@(posedge clk) disable iff (!rstN)
    cpuAck && !cpuWrite |-> cpuReadData == expectedWord)
    else reportFailure($sformatf("FAILED cpuReadData at %h = %h, expected %h",
                                 cpuAdr, cpuReadData, expectedWord));
  assert property (@(posedge clk) disable iff (!rstN)
    hitPulse |-> $past(cpuReq, 2) && !$past(cpuReq, 3))   // Lookup one edge after sampling
    else reportFailure("Hit lookup did not come one edge after the request was taken");
  assert property (@(posedge clk) disable iff (!rstN) hitPulse |=> $rose(cpuAck))
    else reportFailure("cpuAck did not rise right after the hit strobe");
  assert property (@(posedge clk) disable iff (!rstN) expHit |-> !busReq && !missPulse)
    else reportFailure("A line that must be present missed");
  assert property (@(posedge clk) disable iff (!rstN)
    expHit && $rose(cpuAck) |-> $past(hitPulse))
    else reportFailure("A line that must be present was acknowledged without a hit strobe");
  assert property (@(posedge clk) disable iff (!rstN) expMiss |-> !hitPulse)
    else reportFailure("A line that must have been evicted still hit");
  assert property (@(posedge clk) disable iff (!rstN) expMiss && $rose(cpuAck) |-> missSeen)
    else reportFailure("An evicted line was acknowledged without a miss strobe");
  assert property (@(posedge clk) disable iff (!rstN)
    busReq && !busWrite |-> busAdr == {cpuAdr[AdrBits-1:OffsetBits], 4'h0})
    else reportFailure($sformatf("FAILED busAdr = %h, expected %h",
                                 busAdr, {cpuAdr[AdrBits-1:OffsetBits], 4'h0}));
  assert property (@(posedge clk) disable iff (!rstN)
    busReq && busWrite |-> busWriteLine == shadowLine[busAdr[AdrBits-1:OffsetBits]])
    else reportFailure($sformatf("FAILED busWriteLine at %h = %h, expected %h", busAdr,
                                 busWriteLine, shadowLine[busAdr[AdrBits-1:OffsetBits]]));
  assert property (@(posedge clk) disable iff (!rstN)
    busReq && busWrite |-> storedSince[busAdr[AdrBits-1:OffsetBits]])
    else reportFailure($sformatf("Clean line at %h was written back", busAdr));
  assert property (@(posedge clk) disable iff (!rstN) quietBus |-> !busReq)
    else reportFailure("Flush of a clean cache used the bus");
  assert property (@(posedge clk)
    rstN && !started |-> !cpuAck && !flushAck && !busReq && !hitPulse && !missPulse)
    else reportFailure("An output was active after reset before any request");

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    logic [31:0]        ctrl;
    logic [AdrBits-1:0] adr;
    logic [3:0]         mask;
    rstN         = 1'b0;
    cpuReq       = 1'b0;
    cpuWrite     = 1'b0;
    cpuAdr       = '0;
    cpuWriteData = '0;
    cpuByteMask  = '0;
    flushReq     = 1'b0;
    storedSince  = '0;
    expectedWord = '0;
    expHit       = 1'b0;
    expMiss      = 1'b0;
    missSeen     = 1'b0;
    quietBus     = 1'b0;
    started      = 1'b0;
    rndState     = 32'd39154;
    repeat (16) @(posedge clk);
    #5;
    rstN = 1'b1;
    for (int i = 0; i < NumLines; i++) shadowLine[i] = mem0.lineMem[i];
    repeat (3) nextCycle();                                // Idle outputs after reset

    // Four tags over four sets of two ways, so lines get evicted
    for (int n = 0; n < NumOps; n++) begin
      rndState = xorshift32(rndState);
      ctrl     = rndState;
      rndState = xorshift32(rndState);
      adr      = {6'b000100, ctrl[1:0], 2'b00, ctrl[3:2], ctrl[5:4], 2'b00};
      mask     = (ctrl[11:8] == 4'h0) ? 4'hf : ctrl[11:8];
      access(ctrl[6], adr, rndState, mask, 1'b0, 1'b0);
      access(1'b0, adr, '0, '0, 1'b1, 1'b0);             // Same word again
    end

    // Set 5 with tags A, B, C
    access(1'b1, 16'h4054, 32'h1234abcd, 4'hf, 1'b0, 1'b0);
    access(1'b0, 16'h4158, '0, '0, 1'b0, 1'b0);
    access(1'b0, 16'h4054, '0, '0, 1'b1, 1'b0);           // B is now the older way
    access(1'b0, 16'h4250, '0, '0, 1'b0, 1'b1);
    access(1'b0, 16'h405c, '0, '0, 1'b1, 1'b0);
    access(1'b0, 16'h4154, '0, '0, 1'b0, 1'b1);

    flushCache(1'b0);
    compareMemory();
    flushCache(1'b1);                                      // Nothing left dirty
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #(ClkPeriod * WatchdogCycles);
    reportFailure("Run timed out before all operations finished");
  end

endmodule

// File: verilog.f
rtl/cachePkg.sv
rtl/cacheWay.sv
rtl/cacheLru.sv
rtl/cacheFsm.sv
rtl/dataCache.sv
tests/memModel.sv
tests/tbDataCache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbDataCache \
  -f verilog.f -o simDataCache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simDataCache
status=$?
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit $status
fi
exit 0
